//--- verilog/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data path and address width
`define LSU_DATA_W 32

// Byte address of word 0 of the on-chip memory
`define LSU_MEM_BASE 32'h8000_0000

// Memory depth in 32-bit words
`define LSU_MEM_WORDS 256

`endif

//--- verilog/axi_pkg.sv
`default_nettype none

package axi_pkg;

    // Log2 of bytes per beat as on AxSIZE
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2
    } size_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10 // Also used for out-of-window accesses
    } resp_e;

endpackage

`default_nettype wire

//--- verilog/lsu_pkg.sv
`default_nettype none
`include "lsu_consts.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        NONE, // Instruction without memory access
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } mem_op_e;

    typedef struct packed {
        mem_op_e                op;
        logic [`LSU_DATA_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] wdata;
        logic [3:0]             tag;   // Destination register tag
    } lsu_req_t;

    typedef struct packed {
        logic [3:0]             tag;
        logic [`LSU_DATA_W-1:0] data;
        logic                   fault;
    } lsu_resp_t;

endpackage

`default_nettype wire

//--- verilog/axi_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

interface axi_if;

    logic                       awvalid;
    logic                       awready;
    logic [`LSU_DATA_W-1:0]     awaddr;
    axi_pkg::size_e             awsize;
    logic                       wvalid;
    logic                       wready;
    logic [`LSU_DATA_W-1:0]     wdata;
    logic [`LSU_DATA_W/8-1:0]   wstrb;
    logic                       bvalid;
    logic                       bready;
    axi_pkg::resp_e             bresp;
    logic                       arvalid;
    logic                       arready;
    logic [`LSU_DATA_W-1:0]     araddr;
    axi_pkg::size_e             arsize;
    logic                       rvalid;
    logic                       rready;
    logic [`LSU_DATA_W-1:0]     rdata;
    axi_pkg::resp_e             rresp;

    modport master (
        output awvalid, awaddr, awsize, wvalid, wdata, wstrb, bready,
        output arvalid, araddr, arsize, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport slave (
        input  awvalid, awaddr, awsize, wvalid, wdata, wstrb, bready,
        input  arvalid, araddr, arsize, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

`default_nettype wire

//--- verilog/lsu_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_align (
    input  wire lsu_pkg::mem_op_e           op,
    input  wire [`LSU_DATA_W-1:0]           addr,
    input  wire [`LSU_DATA_W-1:0]           wdata,
    input  wire [`LSU_DATA_W-1:0]           bus_rdata,
    output logic [`LSU_DATA_W-1:0]          lane_wdata,
    output logic [3:0]                      wstrb,
    output axi_pkg::size_e                  size,
    output logic [`LSU_DATA_W-1:0]          load_data,
    output logic                            misaligned
);

    logic [1:0]             off;
    logic [`LSU_DATA_W-1:0] shifted;

    assign off = addr[1:0];

    always_comb begin
        case (op)
            lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: size = axi_pkg::SIZE_BYTE;
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: size = axi_pkg::SIZE_HALF;
            default:                                size = axi_pkg::SIZE_WORD;
        endcase
    end

    // NONE carries no access and never faults
    assign misaligned = (op != lsu_pkg::NONE) &&
                        (((size == axi_pkg::SIZE_HALF) && off[0]) ||
                         ((size == axi_pkg::SIZE_WORD) && (off != 2'b00)));

    // Byte lanes follow the low address bits
    assign lane_wdata = wdata << {off, 3'b000};
    assign wstrb = ((size == axi_pkg::SIZE_BYTE) ? 4'b0001 :
                    (size == axi_pkg::SIZE_HALF) ? 4'b0011 : 4'b1111) << off;

    assign shifted = bus_rdata >> {off, 3'b000};

    always_comb begin
        case (op)
            lsu_pkg::LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::LBU: load_data = {24'b0, shifted[7:0]};
            lsu_pkg::LH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::LHU: load_data = {16'b0, shifted[15:0]};
            default:      load_data = shifted;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_ctrl (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 req_valid,
    output logic                req_ready,
    input  wire lsu_pkg::lsu_req_t req,
    output logic                resp_valid,
    output lsu_pkg::lsu_resp_t  resp,
    axi_if.master               axi
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t                 state;
    lsu_pkg::lsu_req_t      req_q;
    lsu_pkg::lsu_req_t      cur;
    logic [`LSU_DATA_W-1:0] lane_wdata;
    logic [3:0]             wstrb;
    axi_pkg::size_e         size;
    logic [`LSU_DATA_W-1:0] load_data;
    logic                   misaligned;
    logic                   accept;
    logic                   short_done;
    logic                   is_store;
    logic                   aw_fire;
    logic                   w_fire;
    logic                   b_fire;
    logic                   ar_fire;
    logic                   r_fire;

    assign req_ready = (state == IDLE);
    assign accept    = req_valid && req_ready;

    // In IDLE decode the incoming request so the first beat leaves next cycle
    assign cur = (state == IDLE) ? req : req_q;

    assign is_store   = cur.op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
    assign short_done = accept && ((req.op == lsu_pkg::NONE) || misaligned);

    lsu_align u_align (
        .op         (cur.op),
        .addr       (cur.addr),
        .wdata      (cur.wdata),
        .bus_rdata  (axi.rdata),
        .lane_wdata (lane_wdata),
        .wstrb      (wstrb),
        .size       (size),
        .load_data  (load_data),
        .misaligned (misaligned)
    );

    // Payload stays stable from the registered request while BUSY
    assign axi.awaddr = req_q.addr;
    assign axi.awsize = size;
    assign axi.wdata  = lane_wdata;
    assign axi.wstrb  = wstrb;
    assign axi.araddr = req_q.addr;
    assign axi.arsize = size;

    assign aw_fire = axi.awvalid && axi.awready;
    assign w_fire  = axi.wvalid && axi.wready;
    assign b_fire  = axi.bvalid && axi.bready;
    assign ar_fire = axi.arvalid && axi.arready;
    assign r_fire  = axi.rvalid && axi.rready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            resp_valid  <= 1'b0;
            axi.awvalid <= 1'b0;
            axi.wvalid  <= 1'b0;
            axi.bready  <= 1'b0;
            axi.arvalid <= 1'b0;
            axi.rready  <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= BUSY;
                        if (short_done) begin
                            resp_valid <= 1'b1;
                        end else if (is_store) begin
                            axi.awvalid <= 1'b1;
                            axi.wvalid  <= 1'b1;
                        end else begin
                            axi.arvalid <= 1'b1;
                        end
                    end
                end
                BUSY: begin
                    if (aw_fire) axi.awvalid <= 1'b0;
                    if (w_fire) axi.wvalid <= 1'b0;
                    // Wait for both the address and the data beat
                    if ((axi.awvalid || axi.wvalid) &&
                        (aw_fire || !axi.awvalid) && (w_fire || !axi.wvalid)) begin
                        axi.bready <= 1'b1;
                    end
                    if (ar_fire) begin
                        axi.arvalid <= 1'b0;
                        axi.rready  <= 1'b1;
                    end
                    if (b_fire || r_fire) begin
                        axi.bready <= 1'b0;
                        axi.rready <= 1'b0;
                        resp_valid <= 1'b1;
                    end
                    if (resp_valid) state <= IDLE; // Response pulse ends the request
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) req_q <= req;
        if (short_done) begin
            resp.tag   <= req.tag;
            resp.data  <= misaligned ? '0 : req.addr;
            resp.fault <= misaligned;
        end else if (b_fire) begin
            resp.tag   <= req_q.tag;
            resp.data  <= '0;
            resp.fault <= (axi.bresp != axi_pkg::RESP_OKAY);
        end else if (r_fire) begin
            resp.tag   <= req_q.tag;
            resp.data  <= load_data;
            resp.fault <= (axi.rresp != axi_pkg::RESP_OKAY);
        end
    end

endmodule

`default_nettype wire

//--- verilog/axi_sram.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module axi_sram (
    input  wire   clk,
    input  wire   rst,
    axi_if.slave  axi
);

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
    localparam logic [`LSU_DATA_W-1:0] MEM_BYTES = `LSU_MEM_WORDS * (`LSU_DATA_W / 8);

    logic [`LSU_DATA_W-1:0] mem [`LSU_MEM_WORDS];
    logic                   wr_fire;
    logic                   ar_fire;
    logic                   wr_ok;
    logic                   rd_ok;
    logic [IDX_W-1:0]       wr_idx;
    logic [IDX_W-1:0]       rd_idx;

    // Whole access must lie inside the window
    function automatic logic in_window(input logic [`LSU_DATA_W-1:0] addr,
                                       input axi_pkg::size_e size);
        logic [`LSU_DATA_W-1:0] off;
        logic [`LSU_DATA_W-1:0] span;
        off  = addr - `LSU_MEM_BASE;
        span = 1 << size;
        return (off < MEM_BYTES) && (off + span <= MEM_BYTES);
    endfunction

    function automatic logic [IDX_W-1:0] word_index(input logic [`LSU_DATA_W-1:0] addr);
        logic [`LSU_DATA_W-1:0] off;
        off = addr - `LSU_MEM_BASE;
        return off[IDX_W+1:2];
    endfunction

    assign wr_ok  = in_window(axi.awaddr, axi.awsize);
    assign rd_ok  = in_window(axi.araddr, axi.arsize);
    assign wr_idx = word_index(axi.awaddr);
    assign rd_idx = word_index(axi.araddr);

    assign axi.arready = !axi.rvalid;
    assign axi.awready = axi.awvalid && axi.wvalid && !axi.bvalid; // aw and w go together
    assign axi.wready  = axi.awready;

    assign wr_fire = axi.awvalid && axi.awready;
    assign ar_fire = axi.arvalid && axi.arready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
                mem[i] <= i; // Word holds its own index
            end
        end else if (wr_fire && wr_ok) begin
            for (int b = 0; b < `LSU_DATA_W / 8; b++) begin
                if (axi.wstrb[b]) mem[wr_idx][8*b +: 8] <= axi.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            axi.rvalid <= 1'b0;
            axi.bvalid <= 1'b0;
        end else begin
            if (ar_fire) axi.rvalid <= 1'b1;
            else if (axi.rready) axi.rvalid <= 1'b0;
            if (wr_fire) axi.bvalid <= 1'b1;
            else if (axi.bready) axi.bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            axi.rdata <= rd_ok ? mem[rd_idx] : '0;
            axi.rresp <= rd_ok ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        end
        if (wr_fire) begin
            axi.bresp <= wr_ok ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

//--- verilog/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_valid,
    output logic                     req_ready,
    input  wire lsu_pkg::mem_op_e    req_op,
    input  wire [`LSU_DATA_W-1:0]    req_addr,
    input  wire [`LSU_DATA_W-1:0]    req_wdata,
    input  wire [3:0]                req_tag,
    output logic                     resp_valid,
    output logic [3:0]               resp_tag,
    output logic [`LSU_DATA_W-1:0]   resp_data,
    output logic                     resp_fault
);

    lsu_pkg::lsu_req_t  req;
    lsu_pkg::lsu_resp_t resp;

    axi_if axi0 ();

    assign req.op    = req_op;
    assign req.addr  = req_addr;
    assign req.wdata = req_wdata;
    assign req.tag   = req_tag;

    lsu_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp),
        .axi        (axi0.master)
    );

    axi_sram u_sram (
        .clk (clk),
        .rst (rst),
        .axi (axi0.slave)
    );

    assign resp_tag   = resp.tag;
    assign resp_data  = resp.data;
    assign resp_fault = resp.fault;

endmodule

`default_nettype wire

//--- verification/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD = 4 // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verification/tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module tb_lsu_top;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_REQ     = 180; // Upper bound on requests issued below
    localparam int MEM_BYTES   = `LSU_MEM_WORDS * 4;
    localparam int WATCHDOG_NS = (NUM_REQ * 8 + 40) * CLK_PERIOD;

    typedef struct {
        logic [3:0]  tag;
        logic [31:0] data;
        logic        check_data;
        logic        fault;
        int          due; // Cycle of the expected resp_valid
    } exp_t;

    logic             clk;
    logic             rst;
    logic             req_valid;
    logic             req_ready;
    lsu_pkg::mem_op_e req_op;
    logic [31:0]      req_addr;
    logic [31:0]      req_wdata;
    logic [3:0]       req_tag;
    logic             resp_valid;
    logic [3:0]       resp_tag;
    logic [31:0]      resp_data;
    logic             resp_fault;

    logic [7:0] model [MEM_BYTES];
    exp_t       exp_q[$];
    logic [3:0] tag_cnt;
    int         cycle = 0;
    int         errors = 0;
    int         n_sent = 0;
    int         n_resp = 0;

    tb_clkgen #(.PERIOD(CLK_PERIOD)) clkgen0 (.clk(clk));

    lsu_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_tag    (req_tag),
        .resp_valid (resp_valid),
        .resp_tag   (resp_tag),
        .resp_data  (resp_data),
        .resp_fault (resp_fault)
    );

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
        errors++;
        $display("error: %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
    endtask

    task automatic protocol_error(input string what);
        errors++;
        $display("Protocol problem at %0t: %s", $time, what);
    endtask

    function automatic logic [31:0] read_model(input logic [31:0] addr, input int nbytes);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbytes; i++) v[8*i +: 8] = model[addr - `LSU_MEM_BASE + i];
        return v;
    endfunction

    // Predicts the response, updates the model, then hands the request over
    task automatic send(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                        input logic [31:0] wdata);
        exp_t e;
        int   nb;
        logic mis;
        logic in_win;
        nb = (op inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB}) ? 1 :
             (op inside {lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH}) ? 2 : 4;
        mis = (op != lsu_pkg::NONE) && ((nb == 2 && addr[0]) || (nb == 4 && addr[1:0] != 2'b00));
        in_win = (addr >= `LSU_MEM_BASE) && (addr - `LSU_MEM_BASE + nb <= MEM_BYTES);
        e.tag = tag_cnt;
        e.check_data = 1'b1;
        e.data = '0;
        e.fault = !in_win;
        e.due = 3;
        if (op == lsu_pkg::NONE || mis) begin
            e.due = 1;
            e.fault = mis;
            e.data = mis ? '0 : addr;
        end else if (op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW}) begin
            e.check_data = 1'b0; // Store data is not defined
            if (in_win) begin
                for (int i = 0; i < nb; i++) model[addr - `LSU_MEM_BASE + i] = wdata[8*i +: 8];
            end
        end else if (in_win) begin
            e.data = read_model(addr, nb);
            if (op == lsu_pkg::LB) e.data = {{24{e.data[7]}}, e.data[7:0]};
            if (op == lsu_pkg::LH) e.data = {{16{e.data[15]}}, e.data[15:0]};
        end
        req_op = op;
        req_addr = addr;
        req_wdata = wdata;
        req_tag = tag_cnt;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk); // Accepted here
        #1;
        req_valid = 1'b0;
        e.due += cycle;
        exp_q.push_back(e);
        tag_cnt++;
        n_sent++;
    endtask

    always @(posedge clk) begin : check_resp
        exp_t e;
        cycle <= cycle + 1;
        if (!rst) begin
            if (exp_q.size() != 0) begin
                assert (!req_ready) else protocol_error("req_ready high with a request outstanding");
            end
            if (resp_valid) begin
                assert (exp_q.size() != 0) else protocol_error("resp_valid with nothing outstanding");
            end
            if (resp_valid && exp_q.size() != 0) begin
                e = exp_q.pop_front();
                n_resp++;
                assert (cycle + 1 == e.due) else protocol_error("response at the wrong cycle");
                assert (resp_tag == e.tag) else value_error("resp_tag", e.tag, resp_tag);
                assert (!e.check_data || resp_data == e.data)
                    else value_error("resp_data", e.data, resp_data);
                assert (resp_fault == e.fault) else value_error("resp_fault", e.fault, resp_fault);
            end
        end
    end

    initial begin : stimulus
        logic [31:0] addr;
        void'($urandom(97));
        rst = 1'b1;
        req_valid = 1'b0;
        req_op = lsu_pkg::NONE;
        req_addr = '0;
        req_wdata = '0;
        req_tag = '0;
        tag_cnt = '0;
        for (int i = 0; i < MEM_BYTES; i++) model[i] = 8'((i / 4) >> (8 * (i % 4)));
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (req_ready === 1'b1) else value_error("req_ready", 1, req_ready);
        assert (resp_valid === 1'b0) else value_error("resp_valid", 0, resp_valid);

        for (int n = 0; n < 4; n++) begin
            addr = `LSU_MEM_BASE + 4 * ($urandom % `LSU_MEM_WORDS);
            send(lsu_pkg::SW, addr, $urandom);
            send(lsu_pkg::LW, addr, 0);
        end

        // Sub-word stores, then every load flavour around the same word
        for (int n = 0; n < 24; n++) begin
            addr = `LSU_MEM_BASE + ($urandom % MEM_BYTES);
            send(n[0] ? lsu_pkg::SH : lsu_pkg::SB, n[0] ? {addr[31:1], 1'b0} : addr, $urandom);
            addr = {addr[31:2], 2'b00};
            send(lsu_pkg::LB, addr + ($urandom % 4), 0);
            send(lsu_pkg::LBU, addr + ($urandom % 4), 0);
            send(lsu_pkg::LH, addr + 2 * ($urandom % 2), 0);
            send(lsu_pkg::LHU, addr + 2 * ($urandom % 2), 0);
            send(lsu_pkg::LW, addr, 0);
        end

        send(lsu_pkg::LW, `LSU_MEM_BASE - 4, 0);
        send(lsu_pkg::LW, `LSU_MEM_BASE + MEM_BYTES, 0);
        send(lsu_pkg::SW, `LSU_MEM_BASE + MEM_BYTES, $urandom); // Would alias word 0
        send(lsu_pkg::SB, `LSU_MEM_BASE - 1, $urandom);
        send(lsu_pkg::LW, `LSU_MEM_BASE, 0);
        send(lsu_pkg::LW, `LSU_MEM_BASE + MEM_BYTES - 4, 0);

        addr = `LSU_MEM_BASE + 4 * ($urandom % `LSU_MEM_WORDS) + 1;
        send(lsu_pkg::LH, addr, 0);
        send(lsu_pkg::LW, addr + 1, 0);
        send(lsu_pkg::SH, addr, $urandom);
        send(lsu_pkg::SW, addr + 2, $urandom);
        send(lsu_pkg::LW, addr - 1, 0);

        for (int n = 0; n < 8; n++) send(lsu_pkg::NONE, $urandom, $urandom);

        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        $display("Closing report: %0d requests, %0d responses, %0d errors", n_sent, n_resp, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired with %0d responses still outstanding", exp_q.size());
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/axi_pkg.sv
verilog/lsu_pkg.sv
verilog/axi_if.sv
verilog/lsu_align.sv
verilog/lsu_ctrl.sv
verilog/axi_sram.sv
verilog/lsu_top.sv
verification/tb_clkgen.sv
verification/tb_lsu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f filelist.f --top-module tb_lsu_top -o sim_lsu > build.log 2>&1 \
    && ./obj_dir/sim_lsu > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
